//--- hdl/rt_wrapper_pkg.sv
`default_nettype none

package rt_wrapper_pkg;

    // Register bus geometry
    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 32;

    // Byte addresses of the register map
    localparam logic [REG_ADDR_W-1:0] ADDR_VERSION   = 8'h00;
    localparam logic [REG_ADDR_W-1:0] ADDR_CYCLE     = 8'h04;
    localparam logic [REG_ADDR_W-1:0] ADDR_DIVISOR   = 8'h08;
    localparam logic [REG_ADDR_W-1:0] ADDR_TRNG_DATA = 8'h0C;  // Write only
    localparam logic [REG_ADDR_W-1:0] ADDR_TRNG_CTRL = 8'h10;  // Bit 0 flushes
    localparam logic [REG_ADDR_W-1:0] ADDR_STATUS    = 8'h14;
    localparam logic [REG_ADDR_W-1:0] ADDR_LOG_DATA  = 8'h18;  // Pops on read

    localparam logic [REG_DATA_W-1:0] FPGA_VERSION = 32'h0001_0200;

    // Log FIFO
    localparam int LOG_CHAR_W = 8;
    localparam int LOG_DEPTH  = 16;
    localparam int LOG_PTR_W  = $clog2(LOG_DEPTH);

    // Entropy FIFO and serializer
    localparam int NIBBLE_W         = 4;
    localparam int NIBBLES_PER_WORD = 8;
    localparam int NIBBLE_IDX_W     = $clog2(NIBBLES_PER_WORD);
    localparam int TRNG_DEPTH       = 4;
    localparam int TRNG_PTR_W       = $clog2(TRNG_DEPTH);

    // Status word bit positions
    localparam int STATUS_LOG_EMPTY  = 0;
    localparam int STATUS_LOG_FULL   = 1;
    localparam int STATUS_TRNG_EMPTY = 2;
    localparam int STATUS_TRNG_FULL  = 3;

    localparam int LOG_VALID_BIT = 8;  // Set when a character came back

    // Entropy word as software writes it, or as the nibbles the core consumes
    typedef union packed {
        logic [REG_DATA_W-1:0]                      word;
        logic [NIBBLES_PER_WORD-1:0][NIBBLE_W-1:0] nibble;  // Nibble 0 is the LSBs
    } trng_word_u;

endpackage

`default_nettype wire

//--- hdl/rt_wrapper_if.sv
`default_nettype none

// Register block to log FIFO read side
interface log_rd_if import rt_wrapper_pkg::*; ();

    logic                  pop;
    logic [LOG_CHAR_W-1:0] head_char;  // First-word-fall-through head
    logic                  empty;
    logic                  full;

    modport regs_side (
        output pop,
        input  head_char,
        input  empty,
        input  full
    );

    modport fifo_side (
        input  pop,
        output head_char,
        output empty,
        output full
    );

endinterface

// Register block to entropy feeder control
interface trng_ctl_if import rt_wrapper_pkg::*; ();

    logic                  push;
    trng_word_u            push_word;
    logic                  flush;
    logic [REG_DATA_W-1:0] divisor;  // Throttle reload value
    logic                  empty;
    logic                  full;

    modport regs_side (
        output push,
        output push_word,
        output flush,
        output divisor,
        input  empty,
        input  full
    );

    modport feeder_side (
        input  push,
        input  push_word,
        input  flush,
        input  divisor,
        output empty,
        output full
    );

endinterface

`default_nettype wire

//--- hdl/rt_wrapper_regs.sv
`default_nettype none

module rt_wrapper_regs import rt_wrapper_pkg::*; (
    input  wire                   core_clk,
    input  wire                   hwif_out,
    input  wire                   reg_wr_en,
    input  wire                   reg_rd_en,
    input  wire  [REG_ADDR_W-1:0] reg_addr,
    input  wire  [REG_DATA_W-1:0] reg_wdata,
    output logic [REG_DATA_W-1:0] reg_rdata,
    log_rd_if.regs_side           log,
    trng_ctl_if.regs_side         trng
);

    logic [REG_DATA_W-1:0] cycle_count;
    logic [REG_DATA_W-1:0] divisor;
    logic [REG_DATA_W-1:0] status_word;
    logic [REG_DATA_W-1:0] log_word;
    logic [REG_DATA_W-1:0] rd_mux;
    logic                  wr_divisor;
    logic                  wr_trng_data;
    logic                  wr_trng_ctrl;
    logic                  rd_log_data;

    // Address decode
    assign wr_divisor   = reg_wr_en && (reg_addr == ADDR_DIVISOR);
    assign wr_trng_data = reg_wr_en && (reg_addr == ADDR_TRNG_DATA);
    assign wr_trng_ctrl = reg_wr_en && (reg_addr == ADDR_TRNG_CTRL);
    assign rd_log_data  = reg_rd_en && (reg_addr == ADDR_LOG_DATA);

    // Strobes act at the same edge as the bus access
    assign trng.push      = wr_trng_data;  // Feeder drops it when full
    assign trng.push_word = trng_word_u'(reg_wdata);
    assign trng.flush     = wr_trng_ctrl && reg_wdata[0];
    assign trng.divisor   = divisor;

    // Pop only when a character is really handed out
    assign log.pop = rd_log_data && !log.empty;

    // Free running and wraps silently
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            divisor <= '0;
        end else if (wr_divisor) begin
            divisor <= reg_wdata;
        end
    end

    always_comb begin
        status_word                    = '0;
        status_word[STATUS_LOG_EMPTY]  = log.empty;
        status_word[STATUS_LOG_FULL]   = log.full;
        status_word[STATUS_TRNG_EMPTY] = trng.empty;
        status_word[STATUS_TRNG_FULL]  = trng.full;
    end

    // Head character plus valid flag or all zeros when nothing is queued
    always_comb begin
        log_word = '0;
        if (!log.empty) begin
            log_word[LOG_CHAR_W-1:0] = log.head_char;
            log_word[LOG_VALID_BIT]  = 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            ADDR_VERSION:  rd_mux = FPGA_VERSION;
            ADDR_CYCLE:    rd_mux = cycle_count;
            ADDR_DIVISOR:  rd_mux = divisor;
            ADDR_STATUS:   rd_mux = status_word;
            ADDR_LOG_DATA: rd_mux = log_word;
            default:       rd_mux = '0;  // Includes the write-only entropy registers
        endcase
    end

    // Read data is held until the next read
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rdata <= '0;
        end else if (reg_rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rt_log_fifo.sv
`default_nettype none

module rt_log_fifo import rt_wrapper_pkg::*; (
    input  wire                  core_clk,
    input  wire                  hwif_out,
    input  wire                  log_char_wr,
    input  wire [LOG_CHAR_W-1:0] log_char,
    log_rd_if.fifo_side          rd
);

    logic [LOG_CHAR_W-1:0] mem [LOG_DEPTH];
    logic [LOG_PTR_W-1:0]  wr_ptr;
    logic [LOG_PTR_W-1:0]  rd_ptr;
    logic [LOG_PTR_W:0]    count;  // One extra bit to tell full from empty
    logic                  do_push;
    logic                  do_pop;

    // Flags come from the registered count
    assign rd.empty = (count == '0);
    assign rd.full  = (count == (LOG_PTR_W+1)'(LOG_DEPTH));

    assign do_push = log_char_wr && !rd.full;  // Overflow characters are lost
    assign do_pop  = rd.pop && !rd.empty;

    assign rd.head_char = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= log_char;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/rt_itrng_feeder.sv
`default_nettype none

module rt_itrng_feeder import rt_wrapper_pkg::*; (
    input  wire                 core_clk,
    input  wire                 hwif_out,
    input  wire                 etrng_req,
    output logic [NIBBLE_W-1:0] itrng_data,
    output logic                itrng_valid,
    trng_ctl_if.feeder_side     ctl
);

    trng_word_u              fifo_mem [TRNG_DEPTH];
    trng_word_u              head;
    logic [TRNG_PTR_W-1:0]   wr_ptr;
    logic [TRNG_PTR_W-1:0]   rd_ptr;
    logic [TRNG_PTR_W:0]     count;
    logic [NIBBLE_IDX_W-1:0] nib_idx;   // Next nibble of the head word
    logic [REG_DATA_W-1:0]   throttle;  // Cycles until the next request sample
    logic                    sample;
    logic                    fire;
    logic                    last_nib;
    logic                    do_push;
    logic                    do_pop;

    assign ctl.empty = (count == '0);
    assign ctl.full  = (count == (TRNG_PTR_W+1)'(TRNG_DEPTH));

    assign head = fifo_mem[rd_ptr];

    // Request is only looked at when the throttle has run out
    assign sample   = (throttle == '0);
    assign fire     = sample && etrng_req && !ctl.empty && !ctl.flush;
    assign last_nib = (nib_idx == NIBBLE_IDX_W'(NIBBLES_PER_WORD - 1));

    assign do_push = ctl.push && !ctl.full && !ctl.flush;
    assign do_pop  = fire && last_nib;  // Word retires after its top nibble

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= ctl.push_word;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else if (ctl.flush) begin
            // Software clear simply forgets the contents
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (fire) begin
                nib_idx <= nib_idx + 1'b1;  // Wraps to 0 with the pop
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Throttle reloads on every sample
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle <= '0;
        end else if (sample) begin
            throttle <= ctl.divisor;
        end else begin
            throttle <= throttle - 1'b1;
        end
    end

    // One-cycle valid with the nibble held afterwards
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            itrng_valid <= 1'b0;
            itrng_data  <= '0;
        end else begin
            itrng_valid <= fire;
            if (fire) begin
                itrng_data <= head.nibble[nib_idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rt_wrapper_top.sv
`default_nettype none

module rt_wrapper_top import rt_wrapper_pkg::*; (
    input  wire                   core_clk,
    input  wire                   hwif_out,

    // Register bus
    input  wire                   reg_wr_en,
    input  wire                   reg_rd_en,
    input  wire  [REG_ADDR_W-1:0] reg_addr,
    input  wire  [REG_DATA_W-1:0] reg_wdata,
    output logic [REG_DATA_W-1:0] reg_rdata,

    // Characters from the core
    input  wire                   log_char_wr,
    input  wire  [LOG_CHAR_W-1:0] log_char,

    // Entropy toward the core
    input  wire                   etrng_req,
    output logic [NIBBLE_W-1:0]   itrng_data,
    output logic                  itrng_valid
);

    log_rd_if   log_rd ();
    trng_ctl_if trng_ctl ();

    rt_wrapper_regs u_regs (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .reg_wr_en (reg_wr_en),
        .reg_rd_en (reg_rd_en),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .log       (log_rd.regs_side),
        .trng      (trng_ctl.regs_side)
    );

    rt_log_fifo u_log_fifo (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .log_char_wr (log_char_wr),
        .log_char    (log_char),
        .rd          (log_rd.fifo_side)
    );

    rt_itrng_feeder u_itrng_feeder (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid),
        .ctl         (trng_ctl.feeder_side)
    );

endmodule

`default_nettype wire

//--- tb/rt_wrapper_tb.sv
`default_nettype none

module rt_wrapper_tb import rt_wrapper_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_GAP    = 9;  // Distance between the two counter reads
    localparam int THROTTLE_DIV = 5;
    localparam int TEST_CYCLES  = 10 + 15 + 60 + 35 + 115 + 85;  // Tests 1 to 6
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * 2 * CLK_PERIOD;

    logic                  core_clk = 1'b0;
    logic                  hwif_out;
    logic                  reg_wr_en;
    logic                  reg_rd_en;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    logic [REG_DATA_W-1:0] reg_rdata;
    logic                  log_char_wr;
    logic [LOG_CHAR_W-1:0] log_char;
    logic                  etrng_req;
    logic [NIBBLE_W-1:0]   itrng_data;
    logic                  itrng_valid;

    // Reference model state
    int                    seed = 85;
    logic                  rd_check = 1'b0;  // Compare reg_rdata at the next edge
    logic [REG_DATA_W-1:0] rd_exp = '0;
    logic [LOG_CHAR_W-1:0] log_model [$];
    logic [NIBBLE_W-1:0]   nib_model [256];  // Nibbles in the order the core must see them
    logic [NIBBLE_W-1:0]   nib_exp;
    int                    nib_wr = 0;
    int                    nib_rd = 0;
    int                    min_gap = 1;
    int                    gap = 1000;       // Edges since the last valid pulse

    rt_wrapper_top u_rt_wrapper_top (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .reg_wr_en   (reg_wr_en),
        .reg_rd_en   (reg_rd_en),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .log_char_wr (log_char_wr),
        .log_char    (log_char),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    assign nib_exp = nib_model[nib_rd[7:0]];

    // Consume one expected nibble per pulse and time the spacing
    always @(posedge core_clk) begin
        if (itrng_valid) begin
            nib_rd <= nib_rd + 1;
            gap    <= 1;
        end else if (gap < 1000) begin
            gap <= gap + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("Error %s exp=%h got=%h", name, exp_val, got_val);
        $display("*** TEST FAILED ***");
        $fatal(1, "Value check failed");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Check failed");
    endtask

    a_rdata: assert property (@(posedge core_clk) rd_check |-> (reg_rdata == rd_exp))
        else report_mismatch("reg_rdata", $sampled(rd_exp), $sampled(reg_rdata));

    a_data_reset: assert property (@(posedge core_clk) $rose(hwif_out) |-> (itrng_data == '0))
        else report_mismatch("itrng_data", '0, $sampled(itrng_data));

    a_req: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> $past(etrng_req))
        else report_failure("itrng_valid pulsed although etrng_req was low");

    a_no_spurious: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> (nib_rd < nib_wr))
        else report_failure("itrng_valid pulsed while no entropy nibble was outstanding");

    a_nibble: assert property (@(posedge core_clk) disable iff (!hwif_out)
        (itrng_valid && (nib_rd < nib_wr)) |-> (itrng_data == nib_exp))
        else report_mismatch("itrng_data", $sampled(nib_exp), $sampled(itrng_data));

    a_throttle: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> (gap >= min_gap))
        else report_failure("itrng_valid pulses came closer together than the divisor allows");

    initial begin
        #(TIMEOUT_NS);
        report_failure("Timeout because the tests did not finish in the expected time");
    end

    function automatic logic [REG_DATA_W-1:0] expected_status(input bit log_empty,
            input bit log_full, input bit trng_empty, input bit trng_full);
        logic [REG_DATA_W-1:0] s;
        s                    = '0;
        s[STATUS_LOG_EMPTY]  = log_empty;
        s[STATUS_LOG_FULL]   = log_full;
        s[STATUS_TRNG_EMPTY] = trng_empty;
        s[STATUS_TRNG_FULL]  = trng_full;
        return s;
    endfunction

    // All stimulus tasks start and end 2 ns after a rising edge
    task automatic expect_rdata(input logic [REG_DATA_W-1:0] value);
        rd_exp   = value;
        rd_check = 1'b1;
        @(posedge core_clk);
        #DRIVE_DELAY;
        rd_check = 1'b0;
    endtask

    task automatic reg_write(input logic [REG_ADDR_W-1:0] addr,
                             input logic [REG_DATA_W-1:0] data);
        reg_wr_en = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge core_clk);
        #DRIVE_DELAY;
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] value);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        @(posedge core_clk);
        #DRIVE_DELAY;
        reg_rd_en = 1'b0;
        expect_rdata(value);
    endtask

    task automatic push_log(input logic [LOG_CHAR_W-1:0] ch);
        log_char_wr = 1'b1;
        log_char    = ch;
        @(posedge core_clk);
        #DRIVE_DELAY;
        log_char_wr = 1'b0;
        if (log_model.size() < LOG_DEPTH) begin
            log_model.push_back(ch);
        end
    endtask

    // Queue a word in the model only if the FIFO had room
    task automatic trng_write(input logic [REG_DATA_W-1:0] data);
        trng_word_u w;
        int         queued;
        w.word = data;
        queued = (nib_wr - nib_rd + NIBBLES_PER_WORD - 1) / NIBBLES_PER_WORD;
        reg_write(ADDR_TRNG_DATA, data);
        if (queued < TRNG_DEPTH) begin
            for (int i = 0; i < NIBBLES_PER_WORD; i++) begin
                nib_model[nib_wr[7:0]] = w.nibble[i];
                nib_wr++;
            end
        end
    endtask

    task automatic wait_drained();
        while (nib_rd != nib_wr) begin
            @(posedge core_clk);
            #DRIVE_DELAY;
        end
    endtask

    initial begin
        logic [REG_DATA_W-1:0] exp_word;
        logic [REG_DATA_W-1:0] first_cycle;
        hwif_out    = 1'b0;
        reg_wr_en   = 1'b0;
        reg_rd_en   = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        log_char_wr = 1'b0;
        log_char    = '0;
        etrng_req   = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk);
        #DRIVE_DELAY;
        hwif_out = 1'b1;

        // Reset values and constants
        expect_rdata('0);
        reg_read(ADDR_STATUS, expected_status(1, 0, 1, 0));
        reg_read(ADDR_VERSION, FPGA_VERSION);
        reg_read(8'h3C, '0);

        // Cycle counter
        reg_rd_en = 1'b1;
        reg_addr  = ADDR_CYCLE;
        @(posedge core_clk);
        #DRIVE_DELAY;
        reg_rd_en   = 1'b0;
        first_cycle = reg_rdata;
        repeat (CYCLE_GAP - 1) @(posedge core_clk);
        #DRIVE_DELAY;
        reg_read(ADDR_CYCLE, first_cycle + CYCLE_GAP);

        // Log FIFO overflow and drain
        for (int i = 0; i < LOG_DEPTH + 2; i++) begin
            push_log(LOG_CHAR_W'($random(seed)));
        end
        reg_read(ADDR_STATUS, expected_status(0, 1, 1, 0));
        while (log_model.size() > 0) begin
            exp_word                   = '0;
            exp_word[LOG_VALID_BIT]    = 1'b1;
            exp_word[LOG_CHAR_W-1:0]   = log_model.pop_front();
            reg_read(ADDR_LOG_DATA, exp_word);
        end
        reg_read(ADDR_LOG_DATA, '0);
        reg_read(ADDR_STATUS, expected_status(1, 0, 1, 0));

        // Entropy nibble order at full rate
        reg_write(ADDR_DIVISOR, 32'd0);
        repeat (3) trng_write($random(seed));
        etrng_req = 1'b1;
        wait_drained();
        etrng_req = 1'b0;
        reg_read(ADDR_STATUS, expected_status(1, 0, 1, 0));

        // Throttled requests
        repeat (8) @(posedge core_clk);
        #DRIVE_DELAY;
        reg_write(ADDR_DIVISOR, THROTTLE_DIV);
        reg_read(ADDR_DIVISOR, THROTTLE_DIV);
        min_gap = THROTTLE_DIV + 1;
        repeat (2) trng_write($random(seed));
        etrng_req = 1'b1;
        wait_drained();
        etrng_req = 1'b0;

        // Full FIFO drops the extra word
        reg_write(ADDR_DIVISOR, 32'd0);
        min_gap = 1;
        repeat (TRNG_DEPTH + 1) trng_write($random(seed));
        reg_read(ADDR_STATUS, expected_status(1, 0, 0, 1));
        etrng_req = 1'b1;
        wait_drained();
        repeat (NIBBLES_PER_WORD * 2) @(posedge core_clk);  // Dropped word would show here
        #DRIVE_DELAY;
        etrng_req = 1'b0;
        reg_read(ADDR_STATUS, expected_status(1, 0, 1, 0));

        // Flush discards queued words
        repeat (2) trng_write($random(seed));
        reg_write(ADDR_TRNG_CTRL, 32'h1);
        nib_wr = nib_rd;
        reg_read(ADDR_STATUS, expected_status(1, 0, 1, 0));
        etrng_req = 1'b1;
        repeat (20) @(posedge core_clk);
        #DRIVE_DELAY;
        etrng_req = 1'b0;

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- rt_wrapper.f
hdl/rt_wrapper_pkg.sv
hdl/rt_wrapper_if.sv
hdl/rt_wrapper_regs.sv
hdl/rt_log_fifo.sv
hdl/rt_itrng_feeder.sv
hdl/rt_wrapper_top.sv
tb/rt_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rt_wrapper_tb \
    -f rt_wrapper.f -Mdir obj_dir > build.log 2>&1 &&
    ./obj_dir/Vrt_wrapper_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
